/* src/icache_pkg.sv */
// shared word type and enums for the instruction cache, imported by the cache RTL and testbench
`default_nettype none

package icache_pkg;

    // instruction word, also used for byte addresses
    typedef logic [31:0] word_t;

    // controller FSM
    typedef enum logic [2:0] {
        LOOKUP,      // compare buffered request against the set
        MISS_REQ,    // waiting for a credit to send the line request
        REFILL,      // collecting line beats
        REFILL_DONE, // write victim way, touch plru, re-read set
        UNC_REQ,     // waiting for a credit to send the word request
        UNC_WAIT,    // waiting for the single beat
        UNC_DONE     // return captured word
    } ctrl_state_t;

    // memory request opcodes
    typedef enum logic {
        OP_LINE = 1'b0, // LINE_WORDS beats from line base
        OP_WORD = 1'b1  // one beat, exact address
    } mem_op_t;

endpackage

`default_nettype wire

/* src/way_store.sv */
// tag, valid and data arrays of all cache ways, registered read index, line-wide fill
`timescale 1ns/10ps
`default_nettype none

module way_store #(
    parameter int WAYS       = 4,
    parameter int SETS       = 64,
    parameter int LINE_WORDS = 4,
    localparam int OFF_W = $clog2(LINE_WORDS) + 2,
    localparam int IDX_W = $clog2(SETS),
    localparam int TAG_W = 32 - IDX_W - OFF_W,
    localparam int WAY_W = $clog2(WAYS)
) (
    input  wire logic                                  clk,
    input  wire logic                                  rst,
    input  wire logic                                  rd_en,
    input  wire logic [IDX_W-1:0]                      rd_index,
    output logic [WAYS-1:0][TAG_W-1:0]                 tag_rd,
    output logic [WAYS-1:0]                            valid_rd,
    output icache_pkg::word_t [WAYS-1:0][LINE_WORDS-1:0] line_rd,
    input  wire logic                                  fill_en,
    input  wire logic [WAY_W-1:0]                      fill_way,
    input  wire logic [IDX_W-1:0]                      fill_index,
    input  wire logic [TAG_W-1:0]                      fill_tag,
    input  wire icache_pkg::word_t [LINE_WORDS-1:0]    fill_line
);
    import icache_pkg::*;

    logic [TAG_W-1:0]           tag_mem  [WAYS][SETS];
    word_t [LINE_WORDS-1:0]     data_mem [WAYS][SETS];
    logic [SETS-1:0]            valid_mem [WAYS];
    logic [IDX_W-1:0]           rd_idx_q;

    // read index register, a fill to the same set shows up on the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_idx_q <= '0;
        end else if (rd_en) begin
            rd_idx_q <= rd_index;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (rst) begin
                valid_mem[w] <= '0;
            end else if (fill_en && fill_way == WAY_W'(w)) begin
                valid_mem[w][fill_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[fill_way][fill_index]  <= fill_tag;
            data_mem[fill_way][fill_index] <= fill_line; // whole line at once
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            tag_rd[w]   = tag_mem[w][rd_idx_q];
            valid_rd[w] = valid_mem[w][rd_idx_q];
            line_rd[w]  = data_mem[w][rd_idx_q];
        end
    end

endmodule

`default_nettype wire

/* src/plru_tree.sv */
// tree pseudo-LRU state per set, touched on hit or fill, gives the victim way for a set
`timescale 1ns/10ps
`default_nettype none

module plru_tree #(
    parameter int WAYS = 4,
    parameter int SETS = 64,
    localparam int IDX_W = $clog2(SETS),
    localparam int WAY_W = $clog2(WAYS)
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             touch,
    input  wire logic [IDX_W-1:0] touch_index,
    input  wire logic [WAY_W-1:0] touch_way,
    input  wire logic [IDX_W-1:0] victim_index,
    output logic [WAY_W-1:0]      victim_way
);

    logic [WAYS-2:0] tree [SETS];

    // follow the bits from the root, 0 goes to the lower half
    function automatic logic [WAY_W-1:0] walk(input logic [WAYS-2:0] bits);
        int               node;
        logic [WAY_W-1:0] way;
        node = 0;
        way  = '0;
        for (int l = 0; l < WAY_W; l++) begin
            way[WAY_W-1-l] = bits[node];
            node = 2 * node + 1 + int'(bits[node]);
        end
        return way;
    endfunction

    // make every node on the path point at the other subtree
    function automatic logic [WAYS-2:0] point_away(input logic [WAYS-2:0] bits,
                                                   input logic [WAY_W-1:0] way);
        int              node;
        logic [WAYS-2:0] nbits;
        node  = 0;
        nbits = bits;
        for (int l = 0; l < WAY_W; l++) begin
            nbits[node] = ~way[WAY_W-1-l];
            node = 2 * node + 1 + int'(way[WAY_W-1-l]);
        end
        return nbits;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) tree[s] <= '0;
        end else if (touch) begin
            tree[touch_index] <= point_away(tree[touch_index], touch_way);
        end
    end

    assign victim_way = walk(tree[victim_index]);

endmodule

`default_nettype wire

/* src/refill_collector.sv */
// collects memory response beats into a cache line and keeps the last beat for uncached fetches
`timescale 1ns/10ps
`default_nettype none

module refill_collector #(
    parameter int LINE_WORDS = 4,
    localparam int CNT_W = $clog2(LINE_WORDS)
) (
    input  wire logic                               clk,
    input  wire logic                               rst,
    input  wire logic                               restart,
    input  wire logic                               mem_rvalid,
    input  wire icache_pkg::word_t                  mem_rdata,
    output icache_pkg::word_t [LINE_WORDS-1:0]      line,
    output logic                                    line_done,
    output icache_pkg::word_t                       beat_word
);

    logic [CNT_W-1:0] beat_cnt;

    // restart drops a partial count left by a single-beat fetch
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            beat_cnt  <= '0;
            line_done <= 1'b0;
        end else begin
            line_done <= 1'b0;
            if (mem_rvalid) begin
                if (beat_cnt == CNT_W'(LINE_WORDS - 1)) begin
                    beat_cnt  <= '0;
                    line_done <= 1'b1; // line complete from next cycle
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    // first beat ends up in word 0
    always_ff @(posedge clk) begin
        if (mem_rvalid) begin
            line      <= {mem_rdata, line[LINE_WORDS-1:1]};
            beat_word <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
// instruction cache controller with request buffer, hit compare, miss/uncached FSM and credits
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl #(
    parameter int WAYS       = 4,
    parameter int SETS       = 64,
    parameter int LINE_WORDS = 4,
    parameter int CREDITS    = 2,
    localparam int WORD_SEL_W = $clog2(LINE_WORDS),
    localparam int OFF_W      = WORD_SEL_W + 2,
    localparam int IDX_W      = $clog2(SETS),
    localparam int TAG_W      = 32 - IDX_W - OFF_W,
    localparam int WAY_W      = $clog2(WAYS)
) (
    input  wire logic                                        clk,
    input  wire logic                                        rst,
    // cpu side
    input  wire logic                                        req,
    input  wire icache_pkg::word_t                           addr,
    input  wire logic                                        cached,
    output logic                                             busy,
    output logic                                             rvalid,
    output icache_pkg::word_t                                rdata,
    // memory request side
    output logic                                             mem_req,
    output icache_pkg::mem_op_t                              mem_op,
    output icache_pkg::word_t                                mem_addr,
    input  wire logic                                        mem_credit,
    input  wire logic                                        mem_rvalid,
    // arrays
    output logic [IDX_W-1:0]                                 rd_index,
    output logic                                             rd_en,
    input  wire logic [WAYS-1:0][TAG_W-1:0]                  tag_rd,
    input  wire logic [WAYS-1:0]                             valid_rd,
    input  wire icache_pkg::word_t [WAYS-1:0][LINE_WORDS-1:0] line_rd,
    output logic                                             fill_en,
    output logic [WAY_W-1:0]                                 fill_way,
    output logic [TAG_W-1:0]                                 fill_tag,
    // plru
    input  wire logic [WAY_W-1:0]                            victim_way,
    output logic                                             plru_touch,
    output logic [WAY_W-1:0]                                 plru_way,
    output logic [IDX_W-1:0]                                 plru_index,
    // refill collector
    input  wire logic                                        line_done,
    input  wire icache_pkg::word_t                           beat_word,
    output logic                                             coll_restart
);
    import icache_pkg::*;

    localparam int CNT_W = $clog2(CREDITS + 1);

    ctrl_state_t       state, state_next;
    logic              buf_valid;
    logic              buf_cached;
    word_t             buf_addr;
    logic [TAG_W-1:0]  buf_tag;
    logic [IDX_W-1:0]  buf_idx;
    logic [WORD_SEL_W-1:0] buf_word;
    logic [WAYS-1:0]   hit_vec;
    logic              hit;
    logic [WAY_W-1:0]  hit_way;
    logic              accept;
    logic              has_credit;
    logic [CNT_W-1:0]  credit_cnt;

    assign buf_tag  = buf_addr[31 -: TAG_W];
    assign buf_idx  = buf_addr[OFF_W +: IDX_W];
    assign buf_word = buf_addr[2 +: WORD_SEL_W];

    // tag compare on the registered array outputs
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_rd[w] && (tag_rd[w] == buf_tag);
            if (hit_vec[w]) hit_way = WAY_W'(w);
        end
    end

    assign hit    = (state == LOOKUP) && buf_valid && buf_cached && |hit_vec;
    assign rvalid = hit || (state == UNC_DONE);
    assign rdata  = (state == UNC_DONE) ? beat_word : line_rd[hit_way][buf_word];
    assign busy   = buf_valid && !rvalid; // miss shows up in the compare cycle
    assign accept = req && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_valid <= 1'b0;
        end else if (accept) begin
            buf_valid <= 1'b1;
        end else if (rvalid) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr   <= addr;
            buf_cached <= cached;
        end
    end

    // array read: new request, or replay of the set after a fill
    assign rd_en    = accept || (state == REFILL_DONE);
    assign rd_index = (state == REFILL_DONE) ? buf_idx : addr[OFF_W +: IDX_W];

    assign fill_en  = (state == REFILL_DONE);
    assign fill_way = victim_way;
    assign fill_tag = buf_tag;

    assign plru_touch = hit || (state == REFILL_DONE);
    assign plru_way   = (state == REFILL_DONE) ? victim_way : hit_way;
    assign plru_index = buf_idx;

    assign coll_restart = (state == UNC_DONE);

    // credits
    assign has_credit = (credit_cnt != '0);
    assign mem_req    = ((state == MISS_REQ) || (state == UNC_REQ)) && has_credit;
    assign mem_op     = (state == UNC_REQ) ? OP_WORD : OP_LINE;
    assign mem_addr   = (state == UNC_REQ) ? buf_addr : {buf_addr[31:OFF_W], {OFF_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= '0;
        end else if (mem_credit && !mem_req && credit_cnt < CNT_W'(CREDITS)) begin
            credit_cnt <= credit_cnt + 1'b1;
        end else if (!mem_credit && mem_req) begin
            credit_cnt <= credit_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) state <= LOOKUP;
        else     state <= state_next;
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (buf_valid && !buf_cached) state_next = UNC_REQ;
                else if (buf_valid && !hit)   state_next = MISS_REQ;
            end
            MISS_REQ:    if (has_credit) state_next = REFILL;
            REFILL:      if (line_done) state_next = REFILL_DONE;
            REFILL_DONE: state_next = LOOKUP; // replay hits next cycle
            UNC_REQ:     if (has_credit) state_next = UNC_WAIT;
            UNC_WAIT:    if (mem_rvalid) state_next = UNC_DONE;
            UNC_DONE:    state_next = LOOKUP;
            default:     state_next = LOOKUP;
        endcase
    end

endmodule

`default_nettype wire

/* src/icache_top.sv */
// instruction cache top level, wires the controller to the arrays, PLRU and refill collector
`timescale 1ns/10ps
`default_nettype none

module icache_top #(
    parameter int WAYS       = 4,
    parameter int SETS       = 64,
    parameter int LINE_WORDS = 4,
    parameter int CREDITS    = 2
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                req,
    input  wire icache_pkg::word_t   addr,
    input  wire logic                cached,
    output logic                     busy,
    output logic                     rvalid,
    output icache_pkg::word_t        rdata,
    output logic                     mem_req,
    output icache_pkg::mem_op_t      mem_op,
    output icache_pkg::word_t        mem_addr,
    input  wire logic                mem_credit,
    input  wire logic                mem_rvalid,
    input  wire icache_pkg::word_t   mem_rdata
);
    import icache_pkg::*;

    localparam int OFF_W = $clog2(LINE_WORDS) + 2;
    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = 32 - IDX_W - OFF_W;
    localparam int WAY_W = $clog2(WAYS);

    logic [IDX_W-1:0]                   rd_index;
    logic                               rd_en;
    logic [WAYS-1:0][TAG_W-1:0]         tag_rd;
    logic [WAYS-1:0]                    valid_rd;
    word_t [WAYS-1:0][LINE_WORDS-1:0]   line_rd;
    logic                               fill_en;
    logic [WAY_W-1:0]                   fill_way;
    logic [TAG_W-1:0]                   fill_tag;
    logic [WAY_W-1:0]                   victim_way;
    logic                               plru_touch;
    logic [WAY_W-1:0]                   plru_way;
    logic [IDX_W-1:0]                   plru_index;
    word_t [LINE_WORDS-1:0]             line;
    logic                               line_done;
    word_t                              beat_word;
    logic                               coll_restart;

    icache_ctrl #(
        .WAYS(WAYS), .SETS(SETS), .LINE_WORDS(LINE_WORDS), .CREDITS(CREDITS)
    ) u_ctrl (
        .clk(clk), .rst(rst),
        .req(req), .addr(addr), .cached(cached),
        .busy(busy), .rvalid(rvalid), .rdata(rdata),
        .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_credit(mem_credit), .mem_rvalid(mem_rvalid),
        .rd_index(rd_index), .rd_en(rd_en),
        .tag_rd(tag_rd), .valid_rd(valid_rd), .line_rd(line_rd),
        .fill_en(fill_en), .fill_way(fill_way), .fill_tag(fill_tag),
        .victim_way(victim_way),
        .plru_touch(plru_touch), .plru_way(plru_way), .plru_index(plru_index),
        .line_done(line_done), .beat_word(beat_word), .coll_restart(coll_restart)
    );

    // fills always target the set held in the read index
    way_store #(
        .WAYS(WAYS), .SETS(SETS), .LINE_WORDS(LINE_WORDS)
    ) u_ways (
        .clk(clk), .rst(rst),
        .rd_en(rd_en), .rd_index(rd_index),
        .tag_rd(tag_rd), .valid_rd(valid_rd), .line_rd(line_rd),
        .fill_en(fill_en), .fill_way(fill_way), .fill_index(rd_index),
        .fill_tag(fill_tag), .fill_line(line)
    );

    plru_tree #(
        .WAYS(WAYS), .SETS(SETS)
    ) u_plru (
        .clk(clk), .rst(rst),
        .touch(plru_touch), .touch_index(plru_index), .touch_way(plru_way),
        .victim_index(plru_index), .victim_way(victim_way)
    );

    refill_collector #(
        .LINE_WORDS(LINE_WORDS)
    ) u_collect (
        .clk(clk), .rst(rst), .restart(coll_restart),
        .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .line(line), .line_done(line_done), .beat_word(beat_word)
    );

endmodule

`default_nettype wire

/* bench/icache_assertions.sv */
// concurrent protocol checks for the cache controller, bound into icache_ctrl by the testbench
`timescale 1ns/10ps
`default_nettype none

module icache_assertions (
    input wire logic                    clk,
    input wire logic                    rst,
    input wire icache_pkg::ctrl_state_t state,
    input wire logic                    req,
    input wire logic                    mem_credit,
    input wire logic                    mem_req,
    input wire logic                    rvalid,
    input wire logic                    busy
);
    import icache_pkg::*;

    logic in_unc;
    int   credits_held; // credit pulses seen minus requests sent
    int   pending;      // accepted requests not yet answered

    assign in_unc = (state == UNC_REQ) || (state == UNC_WAIT) || (state == UNC_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits_held <= 0;
            pending      <= 0;
        end else begin
            credits_held <= credits_held + int'(mem_credit) - int'(mem_req);
            pending      <= pending + int'(req && !busy) - int'(rvalid);
        end
    end

    // a request always spends a credit that is already held
    credit_before_req: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> credits_held > 0)
        else $error("memory request issued with no credit held");

    // an uncached answer goes to the one request in flight
    uncached_single_rvalid: assert property (@(posedge clk) disable iff (rst)
        (rvalid && in_unc) |-> pending == 1)
        else $error("uncached fetch answered with no request outstanding");

    idle_not_busy: assert property (@(posedge clk) disable iff (rst)
        (state == LOOKUP && pending == 0) |-> !busy)
        else $error("busy raised while idle in lookup");

endmodule

`default_nettype wire

/* bench/tb_mem_model.sv */
// memory responder for the cache testbench, hands out credits and returns beats after random delays
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
    parameter int          CREDITS    = 2,
    parameter int          LINE_WORDS = 4,
    parameter int unsigned SEED       = 32'h61f4_7f1a
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                mem_req,
    input  wire icache_pkg::mem_op_t mem_op,
    input  wire icache_pkg::word_t   mem_addr,
    output logic                     mem_credit,
    output logic                     mem_rvalid,
    output icache_pkg::word_t        beat_addr, // data for this address is looked up by the bench
    output int                       req_count,
    output int                       err_count
);
    import icache_pkg::*;

    word_t beat_q[$];
    int    held; // credits handed out and not yet spent
    word_t rng;

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        mem_credit = 1'b0;
        mem_rvalid = 1'b0;
        beat_addr  = '0;
        req_count  = 0;
        err_count  = 0;
        held       = 0;
        rng        = SEED ^ 32'h1357_9bdf;
        forever begin
            @(negedge clk);
            if (rst) begin
                held = 0;
                beat_q.delete();
            end else if (mem_req) begin
                req_count++;
                if (held == 0) begin
                    err_count++;
                    $display("memory model: request at %0t arrived with no credit left", $time);
                end else begin
                    held--;
                end
                if (mem_op == OP_LINE) begin
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        beat_q.push_back(mem_addr + word_t'(4 * i));
                    end
                end else begin
                    beat_q.push_back(mem_addr);
                end
            end
            @(posedge clk);
            mem_credit <= 1'b0;
            mem_rvalid <= 1'b0;
            if (!rst) begin
                rng = xorshift(rng);
                if (held < CREDITS && rng[1:0] == 2'b00) begin
                    mem_credit <= 1'b1;
                    held++;
                end
                if (beat_q.size() != 0 && rng[4:2] < 3'd5) begin // idle gaps between beats
                    mem_rvalid <= 1'b1;
                    beat_addr  <= beat_q.pop_front();
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_icache.sv */
// testbench for the instruction cache, random fetches checked against a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_icache #(
    parameter int unsigned SEED = 32'h61f4_7f1a
);
    import icache_pkg::*;

    localparam int WAYS       = 4;
    localparam int SETS       = 64;
    localparam int LINE_WORDS = 4;
    localparam int CREDITS    = 2;
    localparam int OFF_W      = $clog2(LINE_WORDS) + 2;
    localparam int IDX_W      = $clog2(SETS);
    localparam int NUM_REQS   = 600;
    localparam int TIMEOUT    = 400;

    logic    clk;
    logic    rst;
    logic    req;
    word_t   addr;
    logic    cached;
    logic    busy;
    logic    rvalid;
    word_t   rdata;
    logic    mem_req;
    mem_op_t mem_op;
    word_t   mem_addr;
    logic    mem_credit;
    logic    mem_rvalid;
    word_t   mem_rdata;
    word_t   beat_addr;
    int      mem_reqs;
    int      mem_errs;

    // reference model state
    word_t   rng;
    int      errors;
    int      checks;
    word_t   pend_q[$];
    logic    cur_cached;
    logic    cur_pred_hit;
    logic    cur_first;
    int      cur_lat;
    int      wait_acc;
    int      n_line;
    int      n_word;
    int      snap_line;
    int      snap_word;
    word_t   last_line_addr;
    word_t   last_word_addr;
    mem_op_t last_op;
    word_t   fill_base [SETS]; // last line filled per set
    logic    fill_ok [SETS];
    bit      seen [word_t];
    word_t   prev_addr;
    logic    prev_cached;
    logic    force_repeat;
    logic    accepting;
    logic    timed_out;
    int      issued;

    // fixed memory contents, mixes every address bit
    function automatic word_t word_at(input word_t a);
        word_t m;
        m = a * 32'h9e37_79b1;
        m = m ^ (m >> 15) ^ {a[15:0], a[31:16]};
        return m ^ 32'h3c5a_a5c3;
    endfunction

    function automatic word_t xorshift(input word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // a line spans LINE_WORDS words of 4 bytes
    function automatic word_t line_base(input word_t a);
        return a & ~(word_t'(LINE_WORDS * 4) - 32'd1);
    endfunction

    function automatic logic [IDX_W-1:0] set_of(input word_t a);
        return a[OFF_W +: IDX_W];
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input mem_op_t got, input mem_op_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // small address window so lines repeat and sets overflow
    task automatic pick_request(output word_t a, output logic c);
        rng = xorshift(rng);
        if (force_repeat || (!prev_cached && rng[3])) begin
            a = prev_addr; // cached fetch right after an uncached one
            c = 1'b1;
        end else begin
            if (rng[4]) begin
                a = line_base(prev_addr) | (word_t'(rng[12:11]) << 2);
            end else begin
                a = (word_t'(rng[21:19]) << 10) | (word_t'(rng[17:16]) << 4)
                    | (word_t'(rng[12:11]) << 2);
            end
            c = (rng[26:24] != 3'd0); // 7 in 8 cached
        end
        force_repeat = 1'b0;
    endtask

    task automatic observe_memory();
        if (mem_req) begin
            last_op = mem_op;
            if (mem_op == OP_LINE) begin
                n_line++;
                last_line_addr = mem_addr;
            end else begin
                n_word++;
                last_word_addr = mem_addr;
            end
        end
    endtask

    task automatic record_accept();
        pend_q.push_back(addr);
        cur_cached   = cached;
        cur_lat      = 0;
        wait_acc     = 0;
        snap_line    = n_line;
        snap_word    = n_word;
        cur_pred_hit = cached && fill_ok[set_of(addr)] && fill_base[set_of(addr)] == line_base(addr);
        cur_first    = cached && !seen.exists(line_base(addr));
    endtask

    task automatic check_response();
        word_t a;
        if (pend_q.size() == 0) begin
            errors++;
            $display("rvalid at %0t with no request outstanding", $time);
        end else begin
            a = pend_q.pop_front();
            check_word("rdata", rdata, word_at(a));
            check_bit("busy", busy, 1'b0);
            if (cur_cached) begin
                if (cur_pred_hit) begin
                    check_word("hit latency", word_t'(cur_lat), 32'd1);
                    check_word("line requests on hit", word_t'(n_line - snap_line), 32'd0);
                end
                if (cur_first) begin
                    check_word("line requests on first fetch", word_t'(n_line - snap_line), 32'd1);
                    check_word("mem_addr of line request", last_line_addr, line_base(a));
                    check_op("mem_op of line request", last_op, OP_LINE);
                end
                check_word("word requests on cached fetch", word_t'(n_word - snap_word), 32'd0);
                if (n_line != snap_line) begin
                    fill_base[set_of(a)] = line_base(a);
                    fill_ok[set_of(a)]   = 1'b1;
                    seen[line_base(a)]   = 1'b1;
                end
            end else begin
                check_word("word requests on uncached fetch", word_t'(n_word - snap_word), 32'd1);
                check_word("line requests on uncached fetch", word_t'(n_line - snap_line), 32'd0);
                check_word("mem_addr of word request", last_word_addr, a);
                check_op("mem_op of word request", last_op, OP_WORD);
            end
        end
    endtask

    icache_top #(
        .WAYS(WAYS), .SETS(SETS), .LINE_WORDS(LINE_WORDS), .CREDITS(CREDITS)
    ) dut (
        .clk(clk), .rst(rst),
        .req(req), .addr(addr), .cached(cached),
        .busy(busy), .rvalid(rvalid), .rdata(rdata),
        .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_credit(mem_credit), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
    );

    tb_mem_model #(
        .CREDITS(CREDITS), .LINE_WORDS(LINE_WORDS), .SEED(SEED)
    ) u_mem (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_credit(mem_credit), .mem_rvalid(mem_rvalid), .beat_addr(beat_addr),
        .req_count(mem_reqs), .err_count(mem_errs)
    );

    assign mem_rdata = word_at(beat_addr); // beat data follows the registered beat address

    bind icache_ctrl icache_assertions u_assert (
        .clk(clk), .rst(rst), .state(state), .req(req), .mem_credit(mem_credit),
        .mem_req(mem_req), .rvalid(rvalid), .busy(busy)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        word_t na;
        logic  nc;
        rst    = 1'b1;
        req    = 1'b0;
        addr   = '0;
        cached = 1'b0;
        rng    = SEED;
        errors = 0;
        checks = 0;
        n_line = 0;
        n_word = 0;
        issued = 0;
        cur_lat   = 0;
        wait_acc  = 0;
        timed_out = 1'b0;
        last_op   = OP_LINE;
        last_line_addr = '0;
        last_word_addr = '0;
        for (int s = 0; s < SETS; s++) begin
            fill_ok[s]   = 1'b0;
            fill_base[s] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        // uncached fetch first, then a cached one to the same word
        req          <= 1'b1;
        addr         <= 32'h0000_0448;
        cached       <= 1'b0;
        prev_addr    = 32'h0000_0448;
        prev_cached  = 1'b0;
        force_repeat = 1'b1;
        while (!timed_out && !(issued == NUM_REQS && pend_q.size() == 0)) begin
            @(negedge clk);
            observe_memory();
            if (pend_q.size() != 0) cur_lat++;
            if (rvalid) check_response();
            if (pend_q.size() != 0 && cur_lat > TIMEOUT) begin
                $display("timeout at %0t waiting for rvalid", $time);
                timed_out = 1'b1;
            end
            accepting = req && !busy;
            if (req && busy) begin
                wait_acc++;
                if (wait_acc > TIMEOUT) begin
                    $display("timeout at %0t waiting for busy to drop", $time);
                    timed_out = 1'b1;
                end
            end
            if (accepting) record_accept();
            @(posedge clk);
            if (accepting) begin
                issued++;
                if (issued < NUM_REQS) begin
                    pick_request(na, nc);
                    req    <= 1'b1;
                    addr   <= na;
                    cached <= nc;
                    prev_addr   = na;
                    prev_cached = nc;
                end else begin
                    req <= 1'b0;
                end
            end
        end
        // no stray answers after the last one
        if (!timed_out) begin
            repeat (20) begin
                @(negedge clk);
                if (rvalid) begin
                    errors++;
                    $display("extra rvalid at %0t after all requests were answered", $time);
                end
            end
        end
        $display("requests %0d, memory requests %0d, checks %0d, errors %0d, memory errors %0d",
                 issued, mem_reqs, checks, errors, mem_errs);
        if (errors == 0 && mem_errs == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/icache_pkg.sv
src/way_store.sv
src/plru_tree.sv
src/refill_collector.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/icache_assertions.sv
bench/tb_mem_model.sv
bench/tb_icache.sv

/* Makefile */
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
SEED      ?= 1643413274
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails unless the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP SEED OBJ_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -GSEED=$(SEED) --Mdir $(OBJ_DIR)

test: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(OBJ_DIR)
